// ==== include/rv_core_consts.svh ====
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Width of the integer registers, the PC and the ALU datapath
`define RV_DATA_WIDTH 32

// Register index width, gives the 32 architectural registers
`define RV_REG_ADDR_WIDTH 5

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== sources.f ====
+incdir+include
src/rv_core_pkg.sv
src/rv_regfile.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_control.sv
src/rv_execute.sv
src/rv_core.sv
tb/rv_core_tb.sv

// ==== src/rv_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_control (
    input  wire rv_core_pkg::inst_t         inst_i,
    input  wire                             br_eq_i,
    input  wire                             br_lt_i,
    input  wire                             br_ltu_i,
    output rv_core_pkg::alu_op_e            alu_op_o,
    output rv_core_pkg::op1_sel_e           op1_sel_o,
    output rv_core_pkg::op2_sel_e           op2_sel_o,
    output rv_core_pkg::pc_sel_e            pc_sel_o,
    output logic                            rf_we_o,
    output rv_core_pkg::wb_sel_e            wb_sel_o,
    output logic                            ebreak_o
);

    import rv_core_pkg::*;

    // RV32I base opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [2:0] funct3;
    logic       alt;
    logic       br_taken;
    logic       is_ebreak;

    // alt picks SUB over ADD and SRA over SRL
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt_op);
        case (f3)
            3'b000:  return alt_op ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt_op ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign funct3 = inst_i.r.funct3;
    assign alt    = inst_i.r.funct7[5];

    // Taken decision from the compare flags
    always_comb begin
        case (funct3)
            3'b000:  br_taken = br_eq_i;
            3'b001:  br_taken = !br_eq_i;
            3'b100:  br_taken = br_lt_i;
            3'b101:  br_taken = !br_lt_i;
            3'b110:  br_taken = br_ltu_i;
            3'b111:  br_taken = !br_ltu_i;
            default: br_taken = 1'b0;
        endcase
    end

    // EBREAK is imm 1 with every other field zero
    assign is_ebreak = (inst_i.r.funct7 == 7'd0) && (inst_i.r.rs2 == 5'd1)
                    && (inst_i.r.rs1 == 5'd0) && (funct3 == 3'd0)
                    && (inst_i.r.rd == 5'd0);

    always_comb begin
        alu_op_o  = ALU_ADD;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_RS2;
        pc_sel_o  = PC_PLUS4;
        rf_we_o   = 1'b0;
        wb_sel_o  = WB_ALU;
        ebreak_o  = 1'b0;

        case (inst_i.r.opcode)
            OPC_OP: begin
                rf_we_o  = 1'b1;
                alu_op_o = alu_from_funct3(funct3, alt);
            end
            OPC_OP_IMM: begin
                rf_we_o   = 1'b1;
                op2_sel_o = OP2_IMM_I;
                // funct7 only matters for the shifts here
                alu_op_o  = alu_from_funct3(funct3, (funct3 == 3'b101) && alt);
            end
            OPC_LUI: begin
                rf_we_o   = 1'b1;
                op2_sel_o = OP2_IMM_U;
                alu_op_o  = ALU_COPY2;
            end
            OPC_AUIPC: begin
                rf_we_o   = 1'b1;
                op1_sel_o = OP1_PC;
                op2_sel_o = OP2_IMM_U;
            end
            OPC_JAL: begin
                rf_we_o  = 1'b1;
                wb_sel_o = WB_PC4;
                pc_sel_o = PC_JAL;
            end
            OPC_JALR: begin
                rf_we_o  = 1'b1;
                wb_sel_o = WB_PC4;
                pc_sel_o = PC_JALR;
            end
            OPC_BRANCH: begin
                pc_sel_o = br_taken ? PC_BRANCH : PC_PLUS4;
            end
            OPC_SYSTEM: begin
                ebreak_o = is_ebreak;
            end
            default: begin
                // Unsupported opcode, no write and fall through
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_core (
    input  wire                            clk,
    input  wire                            rst_i,
    // Instruction memory, read in the same cycle
    output logic [`RV_DATA_WIDTH-1:0]      imem_addr_o,
    input  wire [31:0]                     imem_rdata_i,
    // Debug
    input  wire [`RV_REG_ADDR_WIDTH-1:0]   dbg_addr_i,
    output logic [`RV_DATA_WIDTH-1:0]      dbg_data_o,
    output logic [`RV_DATA_WIDTH-1:0]      pc_o,
    output logic                           halted_o
);

    import rv_core_pkg::*;

    inst_t                         inst;
    logic [`RV_DATA_WIDTH-1:0]     pc_plus4;
    logic                          not_halted;

    // Register file addresses and data
    logic [`RV_REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [`RV_REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [`RV_REG_ADDR_WIDTH-1:0] rd_addr;
    logic [`RV_DATA_WIDTH-1:0]     rs1_data;
    logic [`RV_DATA_WIDTH-1:0]     rs2_data;
    logic [`RV_DATA_WIDTH-1:0]     wb_data;

    // Operands, targets and compare flags
    logic [`RV_DATA_WIDTH-1:0]     op1;
    logic [`RV_DATA_WIDTH-1:0]     op2;
    logic [`RV_DATA_WIDTH-1:0]     br_target;
    logic [`RV_DATA_WIDTH-1:0]     jal_target;
    logic [`RV_DATA_WIDTH-1:0]     jalr_target;
    logic                          br_eq;
    logic                          br_lt;
    logic                          br_ltu;

    // Select codes
    alu_op_e                       alu_op;
    op1_sel_e                      op1_sel;
    op2_sel_e                      op2_sel;
    pc_sel_e                       pc_sel;
    wb_sel_e                       wb_sel;
    logic                          rf_we;
    logic                          ebreak;

    assign imem_addr_o = pc_o;
    assign inst        = imem_rdata_i;

    rv_fetch u_fetch (
        .clk           (clk),
        .rst_i         (rst_i),
        .pc_sel_i      (pc_sel),
        .ebreak_i      (ebreak),
        .br_target_i   (br_target),
        .jal_target_i  (jal_target),
        .jalr_target_i (jalr_target),
        .pc_o          (pc_o),
        .pc_plus4_o    (pc_plus4),
        .not_halted_o  (not_halted),
        .halted_o      (halted_o)
    );

    rv_decode u_decode (
        .inst_i        (inst),
        .pc_i          (pc_o),
        .op1_sel_i     (op1_sel),
        .op2_sel_i     (op2_sel),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rd_addr_o     (rd_addr),
        .op1_o         (op1),
        .op2_o         (op2),
        .br_target_o   (br_target),
        .jal_target_o  (jal_target),
        .jalr_target_o (jalr_target),
        .br_eq_o       (br_eq),
        .br_lt_o       (br_lt),
        .br_ltu_o      (br_ltu)
    );

    rv_control u_control (
        .inst_i    (inst),
        .br_eq_i   (br_eq),
        .br_lt_i   (br_lt),
        .br_ltu_i  (br_ltu),
        .alu_op_o  (alu_op),
        .op1_sel_o (op1_sel),
        .op2_sel_o (op2_sel),
        .pc_sel_o  (pc_sel),
        .rf_we_o   (rf_we),
        .wb_sel_o  (wb_sel),
        .ebreak_o  (ebreak)
    );

    rv_execute u_execute (
        .op1_i      (op1),
        .op2_i      (op2),
        .alu_op_i   (alu_op),
        .wb_sel_i   (wb_sel),
        .pc_plus4_i (pc_plus4),
        .wb_data_o  (wb_data)
    );

    rv_regfile u_regfile (
        .clk          (clk),
        .we_i         (rf_we),
        .not_halted_i (not_halted),
        .waddr_i      (rd_addr),
        .wdata_i      (wb_data),
        .raddr1_i     (rs1_addr),
        .raddr2_i     (rs2_addr),
        .dbg_addr_i   (dbg_addr_i),
        .rdata1_o     (rs1_data),
        .rdata2_o     (rs2_data),
        .dbg_data_o   (dbg_data_o)
    );

endmodule

`default_nettype wire

// ==== src/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // ALU operations, COPY2 passes operand 2 through for LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_COPY2
    } alu_op_e;

    typedef enum logic {
        OP1_RS1,
        OP1_PC
    } op1_sel_e;

    typedef enum logic [1:0] {
        OP2_RS2,
        OP2_IMM_I,
        OP2_IMM_U
    } op2_sel_e;

    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pc_sel_e;

    // WB_PC4 writes the link address
    typedef enum logic {
        WB_ALU,
        WB_PC4
    } wb_sel_e;

    // Instruction formats, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // One instruction word seen through every format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_t;

endpackage

`default_nettype wire

// ==== src/rv_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_decode (
    input  wire rv_core_pkg::inst_t        inst_i,
    input  wire [`RV_DATA_WIDTH-1:0]       pc_i,
    input  wire rv_core_pkg::op1_sel_e     op1_sel_i,
    input  wire rv_core_pkg::op2_sel_e     op2_sel_i,
    input  wire [`RV_DATA_WIDTH-1:0]       rs1_data_i,
    input  wire [`RV_DATA_WIDTH-1:0]       rs2_data_i,
    output logic [`RV_REG_ADDR_WIDTH-1:0]  rs1_addr_o,
    output logic [`RV_REG_ADDR_WIDTH-1:0]  rs2_addr_o,
    output logic [`RV_REG_ADDR_WIDTH-1:0]  rd_addr_o,
    output logic [`RV_DATA_WIDTH-1:0]      op1_o,
    output logic [`RV_DATA_WIDTH-1:0]      op2_o,
    output logic [`RV_DATA_WIDTH-1:0]      br_target_o,
    output logic [`RV_DATA_WIDTH-1:0]      jal_target_o,
    output logic [`RV_DATA_WIDTH-1:0]      jalr_target_o,
    output logic                           br_eq_o,
    output logic                           br_lt_o,
    output logic                           br_ltu_o
);

    import rv_core_pkg::*;

    logic [`RV_DATA_WIDTH-1:0] imm_i;
    logic [`RV_DATA_WIDTH-1:0] imm_b;
    logic [`RV_DATA_WIDTH-1:0] imm_u;
    logic [`RV_DATA_WIDTH-1:0] imm_j;
    logic [`RV_DATA_WIDTH-1:0] jalr_sum;

    // Register fields sit in the same bits for every format
    assign rs1_addr_o = inst_i.r.rs1;
    assign rs2_addr_o = inst_i.r.rs2;
    assign rd_addr_o  = inst_i.r.rd;

    // Sign-extended immediates
    assign imm_i = {{(`RV_DATA_WIDTH-12){inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};

    assign imm_b = {{(`RV_DATA_WIDTH-12){inst_i.b.imm_12}},
                    inst_i.b.imm_11,
                    inst_i.b.imm_10_5,
                    inst_i.b.imm_4_1,
                    1'b0};

    assign imm_u = {inst_i.u.imm_31_12, 12'b0};

    assign imm_j = {{(`RV_DATA_WIDTH-20){inst_i.j.imm_20}},
                    inst_i.j.imm_19_12,
                    inst_i.j.imm_11,
                    inst_i.j.imm_10_1,
                    1'b0};

    // Operand muxes
    assign op1_o = (op1_sel_i == OP1_PC) ? pc_i : rs1_data_i;

    always_comb begin
        case (op2_sel_i)
            OP2_IMM_I: op2_o = imm_i;
            OP2_IMM_U: op2_o = imm_u;
            default:   op2_o = rs2_data_i;
        endcase
    end

    // Jump and branch targets
    assign br_target_o  = pc_i + imm_b;
    assign jal_target_o = pc_i + imm_j;

    // JALR clears bit 0 of the sum
    assign jalr_sum      = rs1_data_i + imm_i;
    assign jalr_target_o = {jalr_sum[`RV_DATA_WIDTH-1:1], 1'b0};

    // Branch compares, signed and unsigned
    assign br_eq_o  = (rs1_data_i == rs2_data_i);
    assign br_lt_o  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_ltu_o = (rs1_data_i < rs2_data_i);

endmodule

`default_nettype wire

// ==== src/rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_execute (
    input  wire [`RV_DATA_WIDTH-1:0]    op1_i,
    input  wire [`RV_DATA_WIDTH-1:0]    op2_i,
    input  wire rv_core_pkg::alu_op_e   alu_op_i,
    input  wire rv_core_pkg::wb_sel_e   wb_sel_i,
    input  wire [`RV_DATA_WIDTH-1:0]    pc_plus4_i,
    output logic [`RV_DATA_WIDTH-1:0]   wb_data_o
);

    import rv_core_pkg::*;

    logic [`RV_DATA_WIDTH-1:0] alu_result;
    logic [4:0]                shamt;
    logic                      lt_signed;
    logic                      lt_unsigned;

    // Shift amount is the low 5 bits of operand 2
    assign shamt       = op2_i[4:0];
    assign lt_signed   = ($signed(op1_i) < $signed(op2_i));
    assign lt_unsigned = (op1_i < op2_i);

    always_comb begin
        case (alu_op_i)
            ALU_ADD:   alu_result = op1_i + op2_i;
            ALU_SUB:   alu_result = op1_i - op2_i;
            ALU_SLL:   alu_result = op1_i << shamt;
            ALU_SLT:   alu_result = {{(`RV_DATA_WIDTH-1){1'b0}}, lt_signed};
            ALU_SLTU:  alu_result = {{(`RV_DATA_WIDTH-1){1'b0}}, lt_unsigned};
            ALU_XOR:   alu_result = op1_i ^ op2_i;
            ALU_SRL:   alu_result = op1_i >> shamt;
            ALU_SRA:   alu_result = $unsigned($signed(op1_i) >>> shamt);
            ALU_OR:    alu_result = op1_i | op2_i;
            ALU_AND:   alu_result = op1_i & op2_i;
            ALU_COPY2: alu_result = op2_i;
            default:   alu_result = op1_i + op2_i;
        endcase
    end

    // Link address for JAL and JALR, ALU result otherwise
    assign wb_data_o = (wb_sel_i == WB_PC4) ? pc_plus4_i : alu_result;

endmodule

`default_nettype wire

// ==== src/rv_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_fetch (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire rv_core_pkg::pc_sel_e  pc_sel_i,
    input  wire                        ebreak_i,
    input  wire [`RV_DATA_WIDTH-1:0]   br_target_i,
    input  wire [`RV_DATA_WIDTH-1:0]   jal_target_i,
    input  wire [`RV_DATA_WIDTH-1:0]   jalr_target_i,
    output logic [`RV_DATA_WIDTH-1:0]  pc_o,
    output logic [`RV_DATA_WIDTH-1:0]  pc_plus4_o,
    output logic                       not_halted_o,
    output logic                       halted_o
);

    import rv_core_pkg::*;

    logic [`RV_DATA_WIDTH-1:0] next_pc;

    assign pc_plus4_o = pc_o + `RV_DATA_WIDTH'd4;

    // JALR target comes in with bit 0 already cleared
    always_comb begin
        case (pc_sel_i)
            PC_BRANCH: next_pc = br_target_i;
            PC_JAL:    next_pc = jal_target_i;
            PC_JALR:   next_pc = jalr_target_i;
            default:   next_pc = pc_plus4_o;
        endcase
    end

    // On EBREAK the PC stays on the EBREAK address
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_o     <= `RV_RESET_PC;
            halted_o <= 1'b0;
        end else if (!halted_o) begin
            if (ebreak_i) begin
                halted_o <= 1'b1;
            end else begin
                pc_o <= next_pc;
            end
        end
    end

    // Register write gate, closed in reset as well as after a halt
    assign not_halted_o = !(halted_o || rst_i);

endmodule

`default_nettype wire

// ==== src/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_regfile (
    input  wire                            clk,
    input  wire                            we_i,
    input  wire                            not_halted_i,
    input  wire [`RV_REG_ADDR_WIDTH-1:0]   waddr_i,
    input  wire [`RV_DATA_WIDTH-1:0]       wdata_i,
    input  wire [`RV_REG_ADDR_WIDTH-1:0]   raddr1_i,
    input  wire [`RV_REG_ADDR_WIDTH-1:0]   raddr2_i,
    input  wire [`RV_REG_ADDR_WIDTH-1:0]   dbg_addr_i,
    output logic [`RV_DATA_WIDTH-1:0]      rdata1_o,
    output logic [`RV_DATA_WIDTH-1:0]      rdata2_o,
    output logic [`RV_DATA_WIDTH-1:0]      dbg_data_o
);

    localparam int unsigned DEPTH = 1 << `RV_REG_ADDR_WIDTH;

    logic [`RV_DATA_WIDTH-1:0] regs [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i && not_halted_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is never stored, so every port forces it to zero
    assign rdata1_o   = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o   = (raddr2_i == '0) ? '0 : regs[raddr2_i];
    assign dbg_data_o = (dbg_addr_i == '0) ? '0 : regs[dbg_addr_i];

endmodule

`default_nettype wire

// ==== tb/rv_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_core_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_STEPS    = 34;
    localparam int PROG_WORDS   = 64;

    // RV32I opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [31:0] EBREAK    = 32'h0010_0073;

    logic                          clk;
    logic                          rst_i;
    logic [`RV_DATA_WIDTH-1:0]     imem_addr_o;
    logic [31:0]                   imem_rdata_i;
    logic [`RV_REG_ADDR_WIDTH-1:0] dbg_addr_i;
    logic [`RV_DATA_WIDTH-1:0]     dbg_data_o;
    logic [`RV_DATA_WIDTH-1:0]     pc_o;
    logic                          halted_o;

    // Step table
    logic [31:0] exp_pc     [NUM_STEPS];
    logic [31:0] step_inst  [NUM_STEPS];
    logic [4:0]  probe_rd   [NUM_STEPS];
    logic [31:0] exp_val    [NUM_STEPS];
    logic        exp_halted [NUM_STEPS];
    int          n_steps;

    logic [31:0] prog [PROG_WORDS];

    rv_core UUT (
        .clk          (clk),
        .rst_i        (rst_i),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .dbg_addr_i   (dbg_addr_i),
        .dbg_data_o   (dbg_data_o),
        .pc_o         (pc_o),
        .halted_o     (halted_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Asynchronous instruction read
    assign imem_rdata_i = prog[imem_addr_o[7:2]];

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_step(input logic [31:0] pc, input logic [31:0] inst,
                            input logic [4:0] rd, input logic [31:0] val, input logic halted);
        exp_pc[n_steps]     = pc;
        step_inst[n_steps]  = inst;
        probe_rd[n_steps]   = rd;
        exp_val[n_steps]    = val;
        exp_halted[n_steps] = halted;
        n_steps++;
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "check failed");
    endtask

    task automatic check_state(input int idx);
        assert (pc_o == exp_pc[idx]) else
            report_error($sformatf("step %0d pc_o %h, expected %h", idx, pc_o, exp_pc[idx]));
        assert (imem_addr_o == exp_pc[idx]) else
            report_error($sformatf("step %0d imem_addr_o %h, expected %h",
                                   idx, imem_addr_o, exp_pc[idx]));
        assert (halted_o == exp_halted[idx]) else
            report_error($sformatf("step %0d halted_o %b, expected %b",
                                   idx, halted_o, exp_halted[idx]));
    endtask

    task automatic check_register(input int idx);
        assert (dbg_data_o == exp_val[idx]) else
            report_error($sformatf("step %0d x%0d reads %h, expected %h",
                                   idx, probe_rd[idx], dbg_data_o, exp_val[idx]));
    endtask

    task automatic build_table();
        // x1 = 7 and x2 = -3 feed the ALU and branch cases
        add_step(0,  enc_i(12'd7, 0, 3'b000, 1, OPC_OP_IMM), 1, 32'h0000_0007, 0);
        add_step(4,  enc_i(-12'sd3, 0, 3'b000, 2, OPC_OP_IMM), 2, 32'hFFFF_FFFD, 0);
        add_step(8,  enc_r(7'h00, 2, 1, 3'b000, 3), 3, 32'h0000_0004, 0);
        add_step(12, enc_r(7'h20, 2, 1, 3'b000, 4), 4, 32'h0000_000A, 0);
        add_step(16, enc_r(7'h00, 2, 1, 3'b111, 5), 5, 32'h0000_0005, 0);
        add_step(20, enc_r(7'h00, 2, 1, 3'b110, 6), 6, 32'hFFFF_FFFF, 0);
        add_step(24, enc_r(7'h00, 2, 1, 3'b100, 7), 7, 32'hFFFF_FFFA, 0);
        add_step(28, enc_r(7'h00, 1, 2, 3'b001, 8), 8, 32'hFFFF_FE80, 0);
        add_step(32, enc_r(7'h00, 1, 2, 3'b101, 9), 9, 32'h01FF_FFFF, 0);
        add_step(36, enc_r(7'h20, 1, 2, 3'b101, 10), 10, 32'hFFFF_FFFF, 0);
        add_step(40, enc_r(7'h00, 1, 2, 3'b010, 11), 11, 32'h0000_0001, 0);
        add_step(44, enc_r(7'h00, 1, 2, 3'b011, 12), 12, 32'h0000_0000, 0);
        add_step(48, enc_u(20'h12345, 13, OPC_LUI), 13, 32'h1234_5000, 0);
        add_step(52, enc_u(20'h00001, 14, OPC_AUIPC), 14, 32'h0000_1034, 0);
        // x0 ignores writes and reads as zero
        add_step(56, enc_i(12'd5, 0, 3'b000, 0, OPC_OP_IMM), 0, 32'h0000_0000, 0);
        add_step(60, enc_r(7'h00, 1, 0, 3'b000, 15), 15, 32'h0000_0007, 0);
        // Branches where the next entry's pc shows taken or not
        add_step(64,  enc_b(13'd8, 1, 1, 3'b000), 1, 32'h0000_0007, 0);
        add_step(72,  enc_b(13'd8, 1, 1, 3'b001), 1, 32'h0000_0007, 0);
        add_step(76,  enc_b(13'd8, 2, 1, 3'b001), 2, 32'hFFFF_FFFD, 0);
        add_step(84,  enc_b(13'd8, 1, 2, 3'b100), 1, 32'h0000_0007, 0);
        add_step(92,  enc_b(13'd8, 1, 2, 3'b110), 2, 32'hFFFF_FFFD, 0);
        add_step(96,  enc_b(13'd8, 1, 2, 3'b101), 1, 32'h0000_0007, 0);
        add_step(100, enc_b(13'd8, 1, 2, 3'b111), 2, 32'hFFFF_FFFD, 0);
        add_step(108, enc_b(13'd8, 2, 1, 3'b110), 1, 32'h0000_0007, 0);
        add_step(116, enc_b(13'd12, 2, 1, 3'b101), 1, 32'h0000_0007, 0);
        add_step(128, enc_b(13'd8, 2, 1, 3'b000), 2, 32'hFFFF_FFFD, 0);
        // Jumps with links
        add_step(132, enc_j(21'd12, 16), 16, 32'h0000_0088, 0);
        add_step(144, enc_i(12'd161, 0, 3'b000, 17, OPC_OP_IMM), 17, 32'h0000_00A1, 0);
        add_step(148, enc_i(12'd4, 17, 3'b000, 18, OPC_JALR), 18, 32'h0000_0098, 0);
        // EBREAK then the PC holds while halted
        add_step(164, EBREAK, 5, 32'h0000_0005, 0);
        add_step(164, EBREAK, 5, 32'h0000_0005, 1);
        add_step(164, EBREAK, 5, 32'h0000_0005, 1);
        add_step(164, EBREAK, 5, 32'h0000_0005, 1);
        add_step(164, EBREAK, 5, 32'h0000_0005, 1);
    endtask

    // Watchdog
    initial begin
        #((RESET_CYCLES + 2 * NUM_STEPS) * CLK_PERIOD);
        $display("Watchdog expired, the run did not finish in time");
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        dbg_addr_i  = '0;
        n_steps     = 0;

        // Opcode field of the fill is zero, so stray fetches are no-ops
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = {i[24:0], 7'b0000000};
        end
        build_table();
        for (int k = 0; k < NUM_STEPS; k++) begin
            prog[exp_pc[k][7:2]] = step_inst[k];
        end
        // Word after EBREAK would overwrite x5 if it ever ran
        prog[42] = enc_i(12'd99, 0, 3'b000, 5, OPC_OP_IMM);

        repeat (RESET_CYCLES - 1) @(posedge clk);

        for (int step = 0; step <= NUM_STEPS; step++) begin
            @(posedge clk);
            if (step == 0) begin
                rst_i <= 1'b0;
            end else begin
                dbg_addr_i <= probe_rd[step-1];
            end
            @(negedge clk);
            if (step < NUM_STEPS) begin
                check_state(step);
            end
            if (step > 0) begin
                check_register(step - 1);
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
